// ==== hdl/safe_pkg.sv ====
// ================================================
// Shared widths, bus request/response structs,
// safety mode encoding and the DMR pair table
// ================================================
`default_nettype none

package safe_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    localparam int unsigned NHARTS = 3;
    localparam int unsigned NPAIRS = 3;

    // Core numbers per pair: 0 = {0,1}, 1 = {1,2}, 2 = {0,2}
    localparam int unsigned PAIR_CORE_A [NPAIRS] = '{0, 1, 0};
    localparam int unsigned PAIR_CORE_B [NPAIRS] = '{1, 2, 2};
    localparam int unsigned PAIR_SPARE  [NPAIRS] = '{2, 0, 1};

    // req leads every request struct, so it always sits in the MSB
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } instr_req_t;

    typedef struct packed {
        logic              req;
        logic              we;
        logic [3:0]        be;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    // Shared by instruction and data bus
    typedef struct packed {
        logic              gnt;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } bus_resp_t;

    // Code 2'b11 is not a valid mode
    typedef enum logic [1:0] {
        MODE_INDEP = 2'd0,
        MODE_TMR   = 2'd1,
        MODE_DMR   = 2'd2
    } safe_mode_e;

    typedef struct packed {
        safe_mode_e mode;
        logic [1:0] dmr_pair;
    } mode_cfg_t;

    typedef struct packed {
        logic       tmr_err;
        logic [2:0] tmr_err_id;
        logic       dmr_err;
    } err_status_t;

endpackage

`default_nettype wire

// ==== hdl/tmr_voter.sv ====
// ================================================
// Bitwise three-way majority voter with
// disagreement flag and one-hot odd-core id
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
    parameter type payload_t = logic [31:0]
) (
    input  payload_t [2:0] req_i,
    output payload_t       voted_o,
    output logic           error_o,
    output logic [2:0]     error_id_o
);

    localparam int unsigned W = $bits(payload_t);

    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] c;
    logic [W-1:0] maj;
    logic         any_req;
    logic         ab_eq;
    logic         ac_eq;
    logic         bc_eq;

    assign a = req_i[0];
    assign b = req_i[1];
    assign c = req_i[2];

    // Two out of three per bit
    assign maj     = (a & b) | (a & c) | (b & c);
    assign voted_o = payload_t'(maj);

    // Request strobe is the top bit of the payload
    assign any_req = a[W-1] | b[W-1] | c[W-1];
    assign ab_eq   = (a == b);
    assign ac_eq   = (a == c);
    assign bc_eq   = (b == c);
    assign error_o = any_req && !(ab_eq && bc_eq);

    // Name the odd one out; stays zero if all three differ
    always_comb begin
        error_id_o = 3'b000;
        if (error_o) begin
            if (ab_eq) begin
                error_id_o = 3'b100;
            end else if (ac_eq) begin
                error_id_o = 3'b010;
            end else if (bc_eq) begin
                error_id_o = 3'b001;
            end
        end
    end

    // The flagged core must be the one that lost the vote
    always_comb begin
        assert #0 ($onehot0(error_id_o) &&
                   !((error_id_o[0] && a == maj) ||
                     (error_id_o[1] && b == maj) ||
                     (error_id_o[2] && c == maj)))
            else $error("tmr_voter: error id %b does not name the odd core", error_id_o);
    end

endmodule

`default_nettype wire

// ==== hdl/dmr_comparator.sv ====
// ================================================
// Two-way request comparator, forwards the
// first request and flags any mismatch
// ================================================
`timescale 1ns/1ps
`default_nettype none

module dmr_comparator #(
    parameter type payload_t = logic [31:0]
) (
    input  payload_t req_a_i,
    input  payload_t req_b_i,
    output payload_t fwd_o,
    output logic     mismatch_o
);

    localparam int unsigned W = $bits(payload_t);

    logic [W-1:0] a;
    logic [W-1:0] b;

    assign a = req_a_i;
    assign b = req_b_i;

    // First core of the pair drives the port
    assign fwd_o = req_a_i;

    // Only compare while one of them is actually requesting
    assign mismatch_o = (a[W-1] | b[W-1]) && (a != b);

endmodule

`default_nettype wire

// ==== hdl/safety_bus_mux.sv ====
// ================================================
// Request/response routing between cores and
// system bus ports for INDEP, TMR and DMR modes
// ================================================
`timescale 1ns/1ps
`default_nettype none

module safety_bus_mux
    import safe_pkg::*;
(
    input  mode_cfg_t                cfg_i,

    // Raw core requests
    input  instr_req_t [NHARTS-1:0]  core_instr_req_i,
    input  data_req_t  [NHARTS-1:0]  core_data_req_i,

    // Voted and compared requests
    input  instr_req_t               voted_instr_i,
    input  data_req_t                voted_data_i,
    input  instr_req_t [NPAIRS-1:0]  cmp_instr_i,
    input  data_req_t  [NPAIRS-1:0]  cmp_data_i,

    // System bus side
    input  bus_resp_t  [NHARTS-1:0]  port_instr_resp_i,
    input  bus_resp_t  [NHARTS-1:0]  port_data_resp_i,
    output instr_req_t [NHARTS-1:0]  port_instr_req_o,
    output data_req_t  [NHARTS-1:0]  port_data_req_o,

    // Back to the cores
    output bus_resp_t  [NHARTS-1:0]  core_instr_resp_o,
    output bus_resp_t  [NHARTS-1:0]  core_data_resp_o
);

    int unsigned pair;

    // Pair code 3 falls back to pair 2
    assign pair = (cfg_i.dmr_pair == 2'd3) ? 2 : int'(cfg_i.dmr_pair);

    always_comb begin
        port_instr_req_o  = '0;
        port_data_req_o   = '0;
        core_instr_resp_o = '0;
        core_data_resp_o  = '0;

        unique case (cfg_i.mode)
            MODE_TMR: begin
                // Port 0 only, everybody sees its response
                port_instr_req_o[0] = voted_instr_i;
                port_data_req_o[0]  = voted_data_i;
                for (int i = 0; i < NHARTS; i++) begin
                    core_instr_resp_o[i] = port_instr_resp_i[0];
                    core_data_resp_o[i]  = port_data_resp_i[0];
                end
            end

            MODE_DMR: begin
                port_instr_req_o[0] = cmp_instr_i[pair];
                port_data_req_o[0]  = cmp_data_i[pair];
                // Spare core runs alone on port 1
                port_instr_req_o[1] = core_instr_req_i[PAIR_SPARE[pair]];
                port_data_req_o[1]  = core_data_req_i[PAIR_SPARE[pair]];

                core_instr_resp_o[PAIR_CORE_A[pair]] = port_instr_resp_i[0];
                core_instr_resp_o[PAIR_CORE_B[pair]] = port_instr_resp_i[0];
                core_instr_resp_o[PAIR_SPARE[pair]]  = port_instr_resp_i[1];

                core_data_resp_o[PAIR_CORE_A[pair]] = port_data_resp_i[0];
                core_data_resp_o[PAIR_CORE_B[pair]] = port_data_resp_i[0];
                core_data_resp_o[PAIR_SPARE[pair]]  = port_data_resp_i[1];
            end

            default: begin
                // Independent, straight through
                port_instr_req_o  = core_instr_req_i;
                port_data_req_o   = core_data_req_i;
                core_instr_resp_o = port_instr_resp_i;
                core_data_resp_o  = port_data_resp_i;
            end
        endcase
    end

    // Port 2 must stay quiet in both redundant modes
    always_comb begin
        assert #0 (cfg_i.mode == MODE_INDEP ||
                   (!port_instr_req_o[2].req && !port_data_req_o[2].req))
            else $error("safety_bus_mux: port 2 active in mode %0d", cfg_i.mode);
    end

endmodule

`default_nettype wire

// ==== hdl/safe_mode_ctrl.sv ====
// ================================================
// Mode configuration register and sticky
// TMR/DMR error status
// ================================================
`timescale 1ns/1ps
`default_nettype none

module safe_mode_ctrl
    import safe_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        cfg_load_i,
    input  mode_cfg_t   cfg_i,
    input  logic        err_clear_i,
    input  logic        tmr_instr_err_i,
    input  logic        tmr_data_err_i,
    input  logic [2:0]  tmr_instr_id_i,
    input  logic [2:0]  tmr_data_id_i,
    input  logic [2:0]  pair_instr_mismatch_i,
    input  logic [2:0]  pair_data_mismatch_i,
    output mode_cfg_t   cfg_o,
    output err_status_t err_status_o
);

    mode_cfg_t   cfg_q;
    err_status_t status_q;
    logic        tmr_hit;
    logic        dmr_hit;
    logic [2:0]  tmr_id;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q.mode     <= MODE_INDEP;
            cfg_q.dmr_pair <= 2'd0;
        end else if (cfg_load_i) begin
            cfg_q.mode     <= cfg_i.mode;
            cfg_q.dmr_pair <= (cfg_i.dmr_pair == 2'd3) ? 2'd2 : cfg_i.dmr_pair;
        end
    end

    assign tmr_hit = (cfg_q.mode == MODE_TMR) && (tmr_instr_err_i || tmr_data_err_i);
    // Instruction voter wins a tie
    assign tmr_id  = tmr_instr_err_i ? tmr_instr_id_i : tmr_data_id_i;
    assign dmr_hit = (cfg_q.mode == MODE_DMR) &&
                     (pair_instr_mismatch_i[cfg_q.dmr_pair] ||
                      pair_data_mismatch_i[cfg_q.dmr_pair]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q <= '0;
        end else if (err_clear_i) begin
            status_q <= '0;
        end else begin
            if (tmr_hit) begin
                status_q.tmr_err <= 1'b1;
            end
            // Keep the id of the first fault only
            if (tmr_hit && !status_q.tmr_err) begin
                status_q.tmr_err_id <= tmr_id;
            end
            if (dmr_hit) begin
                status_q.dmr_err <= 1'b1;
            end
        end
    end

    assign cfg_o        = cfg_q;
    assign err_status_o = status_q;

    a_mode_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cfg_q.mode inside {MODE_INDEP, MODE_TMR, MODE_DMR})
        else $error("safe_mode_ctrl: illegal mode stored");

endmodule

`default_nettype wire

// ==== hdl/safe_lockstep_top.sv ====
// ================================================
// Lockstep bus wrapper top: voters, pair
// comparators, bus multiplexer and control
// ================================================
`timescale 1ns/1ps
`default_nettype none

module safe_lockstep_top
    import safe_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    // Configuration and status
    input  logic                     cfg_load_i,
    input  mode_cfg_t                cfg_i,
    input  logic                     err_clear_i,
    output mode_cfg_t                cfg_o,
    output err_status_t              err_status_o,

    // Core side
    input  instr_req_t [NHARTS-1:0]  core_instr_req_i,
    input  data_req_t  [NHARTS-1:0]  core_data_req_i,
    output bus_resp_t  [NHARTS-1:0]  core_instr_resp_o,
    output bus_resp_t  [NHARTS-1:0]  core_data_resp_o,

    // System bus side
    output instr_req_t [NHARTS-1:0]  port_instr_req_o,
    output data_req_t  [NHARTS-1:0]  port_data_req_o,
    input  bus_resp_t  [NHARTS-1:0]  port_instr_resp_i,
    input  bus_resp_t  [NHARTS-1:0]  port_data_resp_i
);

    instr_req_t              voted_instr;
    data_req_t               voted_data;
    logic                    tmr_instr_err;
    logic                    tmr_data_err;
    logic [2:0]              tmr_instr_id;
    logic [2:0]              tmr_data_id;
    instr_req_t [NPAIRS-1:0] cmp_instr;
    data_req_t  [NPAIRS-1:0] cmp_data;
    logic       [NPAIRS-1:0] pair_instr_mismatch;
    logic       [NPAIRS-1:0] pair_data_mismatch;

    safe_mode_ctrl u_safe_mode_ctrl (
        .clk_i                 (clk_i),
        .arst_n_i              (arst_n_i),
        .cfg_load_i            (cfg_load_i),
        .cfg_i                 (cfg_i),
        .err_clear_i           (err_clear_i),
        .tmr_instr_err_i       (tmr_instr_err),
        .tmr_data_err_i        (tmr_data_err),
        .tmr_instr_id_i        (tmr_instr_id),
        .tmr_data_id_i         (tmr_data_id),
        .pair_instr_mismatch_i (pair_instr_mismatch),
        .pair_data_mismatch_i  (pair_data_mismatch),
        .cfg_o                 (cfg_o),
        .err_status_o          (err_status_o)
    );

    tmr_voter #(.payload_t(instr_req_t)) u_tmr_voter_instr (
        .req_i      (core_instr_req_i),
        .voted_o    (voted_instr),
        .error_o    (tmr_instr_err),
        .error_id_o (tmr_instr_id)
    );

    tmr_voter #(.payload_t(data_req_t)) u_tmr_voter_data (
        .req_i      (core_data_req_i),
        .voted_o    (voted_data),
        .error_o    (tmr_data_err),
        .error_id_o (tmr_data_id)
    );

    // One instruction and one data comparator per core pair
    for (genvar p = 0; p < NPAIRS; p++) begin : pair_cmp
        dmr_comparator #(.payload_t(instr_req_t)) u_cmp_instr (
            .req_a_i    (core_instr_req_i[PAIR_CORE_A[p]]),
            .req_b_i    (core_instr_req_i[PAIR_CORE_B[p]]),
            .fwd_o      (cmp_instr[p]),
            .mismatch_o (pair_instr_mismatch[p])
        );

        dmr_comparator #(.payload_t(data_req_t)) u_cmp_data (
            .req_a_i    (core_data_req_i[PAIR_CORE_A[p]]),
            .req_b_i    (core_data_req_i[PAIR_CORE_B[p]]),
            .fwd_o      (cmp_data[p]),
            .mismatch_o (pair_data_mismatch[p])
        );
    end

    safety_bus_mux u_safety_bus_mux (
        .cfg_i             (cfg_o),
        .core_instr_req_i  (core_instr_req_i),
        .core_data_req_i   (core_data_req_i),
        .voted_instr_i     (voted_instr),
        .voted_data_i      (voted_data),
        .cmp_instr_i       (cmp_instr),
        .cmp_data_i        (cmp_data),
        .port_instr_resp_i (port_instr_resp_i),
        .port_data_resp_i  (port_data_resp_i),
        .port_instr_req_o  (port_instr_req_o),
        .port_data_req_o   (port_data_req_o),
        .core_instr_resp_o (core_instr_resp_o),
        .core_data_resp_o  (core_data_resp_o)
    );

endmodule

`default_nettype wire

// ==== include/tb_cases.svh ====
// ================================================
// Test case table: mode, corrupted core and bus,
// clear request and expected error status
// ================================================
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef struct packed {
    mode_cfg_t   cfg;
    logic [2:0]  bad_core;
    logic [1:0]  bad_bus;
    logic        clear;
    err_status_t exp;
} case_row_t;

// Columns: name, mode, pair, corrupted core (one-hot), corrupted bus
// (bit 0 instr, bit 1 data), clear, expected {tmr_err, tmr_err_id, dmr_err}
task automatic fill_case_table();
    add_case("indep_base",     MODE_INDEP, 2'd0, 3'b000, 2'b00, 1'b0, 5'b0_000_0);
    add_case("tmr_clean",      MODE_TMR,   2'd0, 3'b000, 2'b00, 1'b0, 5'b0_000_0);
    add_case("tmr_core1_instr", MODE_TMR,  2'd0, 3'b010, 2'b01, 1'b0, 5'b1_010_0);
    // Second fault keeps the first id
    add_case("tmr_core2_data", MODE_TMR,   2'd0, 3'b100, 2'b10, 1'b1, 5'b1_010_0);
    add_case("dmr_p0_core0",   MODE_DMR,   2'd0, 3'b001, 2'b01, 1'b1, 5'b0_000_1);
    add_case("dmr_p1_spare",   MODE_DMR,   2'd1, 3'b001, 2'b11, 1'b0, 5'b0_000_0);
    add_case("dmr_p1_core2",   MODE_DMR,   2'd1, 3'b100, 2'b10, 1'b1, 5'b0_000_1);
    // Pair code 3 acts as pair 2
    add_case("dmr_p3_spare",   MODE_DMR,   2'd3, 3'b010, 2'b01, 1'b0, 5'b0_000_0);
    add_case("dmr_p2_core2",   MODE_DMR,   2'd2, 3'b100, 2'b11, 1'b1, 5'b0_000_1);
    add_case("indep_fault",    MODE_INDEP, 2'd0, 3'b001, 2'b11, 1'b0, 5'b0_000_0);
    // Data voter alone raises the flag here
    add_case("tmr_core0_data", MODE_TMR,   2'd0, 3'b001, 2'b10, 1'b1, 5'b1_001_0);
endtask

`endif

// ==== sim/tb_safe_lockstep.sv ====
// ================================================
// Testbench for the lockstep bus wrapper: case
// table loop, routing model, status checks
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_safe_lockstep
    import safe_pkg::*;
;

    `include "tb_cases.svh"

    // First core, second core and spare per pair code, code 3 maps to pair 2
    localparam int unsigned FIRST_CORE  [4] = '{0, 1, 0, 0};
    localparam int unsigned SECOND_CORE [4] = '{1, 2, 2, 2};
    localparam int unsigned SPARE_CORE  [4] = '{2, 0, 1, 1};

    logic              clk = 1'b0;
    logic              arst_n;
    logic              cfg_load;
    mode_cfg_t         cfg;
    logic              err_clear;
    mode_cfg_t         cfg_o;
    err_status_t       err_status;
    instr_req_t  [2:0] core_instr_req;
    data_req_t   [2:0] core_data_req;
    bus_resp_t   [2:0] core_instr_resp;
    bus_resp_t   [2:0] core_data_resp;
    instr_req_t  [2:0] port_instr_req;
    data_req_t   [2:0] port_data_req;
    bus_resp_t   [2:0] port_instr_resp;
    bus_resp_t   [2:0] port_data_resp;

    instr_req_t  common_instr;
    data_req_t   common_data;
    logic [31:0] lfsr = 32'h10f4319e;
    case_row_t   rows [$];
    string       names [$];
    string       cur_name;
    int unsigned mismatches = 0;
    int unsigned failures = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 50;

    safe_lockstep_top u_safe_lockstep_top (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .cfg_load_i        (cfg_load),
        .cfg_i             (cfg),
        .err_clear_i       (err_clear),
        .cfg_o             (cfg_o),
        .err_status_o      (err_status),
        .core_instr_req_i  (core_instr_req),
        .core_data_req_i   (core_data_req),
        .core_instr_resp_o (core_instr_resp),
        .core_data_resp_o  (core_data_resp),
        .port_instr_req_o  (port_instr_req),
        .port_data_req_o   (port_data_req),
        .port_instr_resp_i (port_instr_resp),
        .port_data_resp_i  (port_data_resp)
    );

    always #5 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int unsigned i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    task automatic add_case(input string name, input safe_mode_e mode, input logic [1:0] pair,
                            input logic [2:0] bad_core, input logic [1:0] bad_bus,
                            input logic clear, input logic [4:0] exp_status);
        case_row_t row;
        row.cfg.mode     = mode;
        row.cfg.dmr_pair = pair;
        row.bad_core     = bad_core;
        row.bad_bus      = bad_bus;
        row.clear        = clear;
        row.exp          = exp_status;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic next_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [69:0] exp_v,
                               input logic [69:0] act_v);
        assert (act_v === exp_v) else begin
            mismatches++;
            $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
        end
    endtask

    task automatic drive_idle();
        core_instr_req  = '0;
        core_data_req   = '0;
        port_instr_resp = '0;
        port_data_resp  = '0;
    endtask

    // Same request on all cores, each core gets its own in independent mode
    task automatic drive_random(input safe_mode_e mode, input logic [2:0] bad_core,
                                input logic [1:0] bad_bus);
        logic [4:0] pos;
        common_instr.req   = 1'b1;
        common_instr.addr  = rand_bits(32);
        common_data.req    = 1'b1;
        common_data.we     = 1'(rand_bits(1));
        common_data.be     = 4'(rand_bits(4));
        common_data.addr   = rand_bits(32);
        common_data.wdata  = rand_bits(32);
        for (int i = 0; i < 3; i++) begin
            core_instr_req[i] = common_instr;
            core_data_req[i]  = common_data;
            if (mode == MODE_INDEP) begin
                core_instr_req[i].addr = rand_bits(32);
                core_data_req[i].wdata = rand_bits(32);
            end
            if (bad_core[i]) begin
                pos = 5'(rand_bits(5));
                if (bad_bus[0]) begin
                    core_instr_req[i].addr[pos] = ~core_instr_req[i].addr[pos];
                end
                if (bad_bus[1]) begin
                    core_data_req[i].wdata[pos] = ~core_data_req[i].wdata[pos];
                end
            end
            port_instr_resp[i] = '{1'(rand_bits(1)), 1'(rand_bits(1)), rand_bits(32)};
            port_data_resp[i]  = '{1'(rand_bits(1)), 1'(rand_bits(1)), rand_bits(32)};
        end
    endtask

    // Reference routing, majority in TMR is the shared copy with one core corrupted
    task automatic check_routing(input mode_cfg_t mode_cfg);
        instr_req_t [2:0] exp_ireq;
        data_req_t  [2:0] exp_dreq;
        bus_resp_t  [2:0] exp_iresp;
        bus_resp_t  [2:0] exp_dresp;
        int unsigned      a;
        int unsigned      b;
        int unsigned      s;
        a         = FIRST_CORE[mode_cfg.dmr_pair];
        b         = SECOND_CORE[mode_cfg.dmr_pair];
        s         = SPARE_CORE[mode_cfg.dmr_pair];
        exp_ireq  = '0;
        exp_dreq  = '0;
        exp_iresp = '0;
        exp_dresp = '0;
        case (mode_cfg.mode)
            MODE_TMR: begin
                exp_ireq[0] = common_instr;
                exp_dreq[0] = common_data;
                for (int i = 0; i < 3; i++) begin
                    exp_iresp[i] = port_instr_resp[0];
                    exp_dresp[i] = port_data_resp[0];
                end
            end
            MODE_DMR: begin
                exp_ireq[0]  = core_instr_req[a];
                exp_dreq[0]  = core_data_req[a];
                exp_ireq[1]  = core_instr_req[s];
                exp_dreq[1]  = core_data_req[s];
                exp_iresp[a] = port_instr_resp[0];
                exp_iresp[b] = port_instr_resp[0];
                exp_iresp[s] = port_instr_resp[1];
                exp_dresp[a] = port_data_resp[0];
                exp_dresp[b] = port_data_resp[0];
                exp_dresp[s] = port_data_resp[1];
            end
            default: begin
                exp_ireq  = core_instr_req;
                exp_dreq  = core_data_req;
                exp_iresp = port_instr_resp;
                exp_dresp = port_data_resp;
            end
        endcase
        for (int p = 0; p < 3; p++) begin
            check_value($sformatf("port%0d instr req", p),
                        70'(exp_ireq[p]), 70'(port_instr_req[p]));
            check_value($sformatf("port%0d data req", p),
                        70'(exp_dreq[p]), 70'(port_data_req[p]));
            check_value($sformatf("core%0d instr resp", p),
                        70'(exp_iresp[p]), 70'(core_instr_resp[p]));
            check_value($sformatf("core%0d data resp", p),
                        70'(exp_dresp[p]), 70'(core_data_resp[p]));
        end
    endtask

    // Load, then 8 random cycles with the fault in the first one only
    task automatic run_case(input int unsigned idx);
        case_row_t row;
        mode_cfg_t exp_cfg;
        row      = rows[idx];
        cur_name = names[idx];
        exp_cfg  = row.cfg;
        if (row.cfg.dmr_pair == 2'd3) begin
            exp_cfg.dmr_pair = 2'd2;
        end
        next_drive_slot();
        cfg_load = 1'b1;
        cfg      = row.cfg;
        for (int c = 0; c < 8; c++) begin
            next_drive_slot();
            cfg_load = 1'b0;
            drive_random(row.cfg.mode, (c == 0) ? row.bad_core : 3'b000, row.bad_bus);
            #4;
            if (c == 0) begin
                check_value("cfg_o", 70'(exp_cfg), 70'(cfg_o));
            end
            check_routing(row.cfg);
            if (c > 0) begin
                check_value("status", 70'(row.exp), 70'(err_status));
            end
        end
        next_drive_slot();
        drive_idle();
        err_clear = row.clear;
        #4;
        check_value("final status", 70'(row.exp), 70'(err_status));
        if (row.clear) begin
            next_drive_slot();
            err_clear = 1'b0;
            #4;
            check_value("status after clear", '0, 70'(err_status));
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    endtask

    initial begin
        arst_n    = 1'b0;
        cfg_load  = 1'b0;
        cfg       = '{MODE_INDEP, 2'd0};
        err_clear = 1'b0;
        drive_idle();
        fill_case_table();
        cycle_limit = rows.size() * 12 + 50;
        repeat (16) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        cur_name = "reset";
        #4;
        // MODE_INDEP with pair 0 encodes as all zero
        check_value("cfg_o", '0, 70'(cfg_o));
        check_value("status", '0, 70'(err_status));
        for (int unsigned i = 0; i < rows.size(); i++) begin
            run_case(i);
        end
        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        failures++;
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== safe_lockstep.f ====
+incdir+include
hdl/safe_pkg.sv
hdl/tmr_voter.sv
hdl/dmr_comparator.sv
hdl/safety_bus_mux.sv
hdl/safe_mode_ctrl.sv
hdl/safe_lockstep_top.sv
sim/tb_safe_lockstep.sv

// ==== Makefile ====
TOP = tb_safe_lockstep

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f safe_lockstep.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
